// ==== build.f ====
+incdir+include
hdl/ib_frame_pkg.sv
hdl/ib_bus_pkg.sv
hdl/lane_skew_line.sv
hdl/slot_write_ctrl.sv
hdl/word_bank.sv
hdl/ib_addr_ctrl_top.sv
verification/ib_tb_top.sv

// ==== verification/ib_tb_top.sv ====
`include "ib_macros.svh"

module ib_tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADR_W       = `IB_LANE_BITS + `IB_SLOT_BITS;
    localparam int STREAM_BITS = `IB_WORD_BITS * `IB_SLOTS;
    localparam int EXTRA_WORDS = 2;

    // Four frames of about 300 cycles plus three readbacks of 128 reads at 3 cycles
    // come to about 2500 cycles, so the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 10000;
    localparam int ACK_LIMIT      = 16;
    localparam int DONE_LIMIT     = 4 * `IB_LANES;

    logic                     clk;
    logic                     rst_n;
    logic [`IB_LANES-1:0]     bit_in;
    logic                     bit_valid;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [ADR_W-1:0]         wb_adr;
    logic [`IB_WORD_BITS-1:0] wb_dat_o;
    logic                     wb_ack;
    logic                     busy;
    logic                     done;

    logic [31:0]              rng_state;
    logic [`IB_WORD_BITS-1:0] exp_words [`IB_LANES][`IB_SLOTS];
    // Bits still to send per lane with the next bit at the MSB
    logic [STREAM_BITS-1:0]   lane_fifo [`IB_LANES];

    int errors;
    int tests_failed;
    int cycle_count;
    int busy_faults;
    int done_faults;

    ib_addr_ctrl_top ib_addr_ctrl_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .bit_in    (bit_in),
        .bit_valid (bit_valid),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        bit_valid <= 1'b0;
        bit_in    <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Slot 0 goes out first, so it sits at the top of each lane's stream
    task automatic load_frame();
        for (int k = 0; k < `IB_LANES; k++) begin
            lane_fifo[k] = '0;
            for (int s = 0; s < `IB_SLOTS; s++) begin
                exp_words[k][s] = next_random();
                lane_fifo[k] = {lane_fifo[k][STREAM_BITS-`IB_WORD_BITS-1:0], exp_words[k][s]};
            end
        end
    endtask

    task automatic load_extra(input int nwords);
        for (int k = 0; k < `IB_LANES; k++) begin
            lane_fifo[k] = '0;
            for (int w = 0; w < nwords; w++) begin
                lane_fifo[k] = {lane_fifo[k][STREAM_BITS-`IB_WORD_BITS-1:0], next_random()};
            end
            lane_fifo[k] = lane_fifo[k] << (`IB_WORD_BITS * (`IB_SLOTS - nwords));
        end
    endtask

    // Sends nbeats beats, lane k getting each bit k cycles after its valid,
    // and tallies flag faults on the way
    task automatic run_beats(input int nbeats, input bit gaps, input bit after_done);
        logic [`IB_LANES-1:0] vhist;
        logic [`IB_LANES-1:0] bits;
        logic [31:0]          noise;
        logic                 v;
        int                   sent;
        int                   prev_sent;
        sent        = 0;
        vhist       = '0;
        busy_faults = 0;
        done_faults = 0;
        while (sent < nbeats || vhist != '0) begin
            @(posedge clk);
            prev_sent = sent;
            noise     = next_random();
            // With gaps about one beat in four is left empty
            v     = (sent < nbeats) && (!gaps || noise[1:0] != 2'b00);
            vhist = {vhist[`IB_LANES-2:0], v};
            for (int k = 0; k < `IB_LANES; k++) begin
                if (vhist[k]) begin
                    bits[k]      = lane_fifo[k][STREAM_BITS-1];
                    lane_fifo[k] = lane_fifo[k] << 1;
                end else begin
                    bits[k] = noise[k];
                end
            end
            bit_valid <= v;
            bit_in    <= bits;
            if (v) begin
                sent++;
            end
            @(negedge clk);
            // busy needs a sampled beat and stays low once the frame is done
            if (busy !== ((prev_sent > 0) && !after_done)) begin
                busy_faults++;
            end
            if (done !== after_done) begin
                done_faults++;
            end
        end
        @(posedge clk);
        bit_valid <= 1'b0;
        bit_in    <= '0;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < DONE_LIMIT) begin
            if (!busy) begin
                busy_faults++;
            end
            @(negedge clk);
            n++;
        end
        assert (done) else begin
            $display("Frame never finished, done still low %0d cycles after the last beat",
                     DONE_LIMIT);
            errors++;
        end
        // done rises and busy falls one cycle after lane 31's last write
        if (n != 0) begin
            done_faults++;
        end
        if (busy) begin
            busy_faults++;
        end
    endtask

    //////////////////////////////////////////////////
    // Wishbone read and readback
    //////////////////////////////////////////////////

    task automatic read_expect(input logic [ADR_W-1:0] adr,
                               input logic [`IB_WORD_BITS-1:0] exp);
        int waited;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(negedge clk);
        waited = 0;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (wb_ack) else begin
            $display("Read of address %0d was never acknowledged", adr);
            errors++;
        end
        if (wb_ack) begin
            assert (waited == 1) else begin
                $display("error at %0d ns: address %0d acknowledged after %0d cycles, expected 1",
                         $time, adr, waited);
                errors++;
            end
            assert (wb_dat_o == exp) else begin
                $display("error at %0d ns: lane %0d slot %0d read %h, expected %h", $time,
                         adr[ADR_W-1:`IB_SLOT_BITS], adr[`IB_SLOT_BITS-1:0], wb_dat_o, exp);
                errors++;
            end
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk);
        assert (!wb_ack) else begin
            $display("error at %0d ns: ack still high after read of address %0d", $time, adr);
            errors++;
        end
    endtask

    // Word of lane k, slot s lives at k*slots+s
    task automatic readback_frame();
        for (int k = 0; k < `IB_LANES; k++) begin
            for (int s = 0; s < `IB_SLOTS; s++) begin
                read_expect(ADR_W'(k * `IB_SLOTS + s), exp_words[k][s]);
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int start);
        if (errors == start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - start);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        int start;
        start = errors;
        @(negedge clk);
        assert (!busy && !done) else begin
            $display("error at %0d ns: busy %b done %b after reset, expected both low",
                     $time, busy, done);
            errors++;
        end
        read_expect(ADR_W'(0), '0);
        read_expect(ADR_W'(1), '0);
        read_expect(ADR_W'(42), '0);
        read_expect('1, '0);
        report_test(1, "reset state", start);
    endtask

    task automatic test_full_frame();
        int start;
        start = errors;
        load_frame();
        run_beats(STREAM_BITS, 1'b0, 1'b0);
        wait_for_done();
        readback_frame();
        report_test(2, "full frame", start);
    endtask

    // Checks the flag faults tallied while the full frame ran
    task automatic test_flags();
        int start;
        start = errors;
        @(negedge clk);
        assert (busy_faults == 0) else begin
            $display("error at %0d ns: busy wrong in %0d cycles of the frame",
                     $time, busy_faults);
            errors++;
        end
        assert (done_faults == 0) else begin
            $display("error at %0d ns: done wrong in %0d cycles of the frame",
                     $time, done_faults);
            errors++;
        end
        assert (done && !busy) else begin
            $display("error at %0d ns: busy %b done %b after the frame, expected 0 and 1",
                     $time, busy, done);
            errors++;
        end
        report_test(3, "flags", start);
    endtask

    task automatic test_gaps();
        int start;
        start = errors;
        apply_reset();
        @(negedge clk);
        assert (!done && !busy) else begin
            $display("error at %0d ns: flags not cleared by reset", $time);
            errors++;
        end
        load_frame();
        run_beats(STREAM_BITS, 1'b1, 1'b0);
        wait_for_done();
        readback_frame();
        report_test(4, "frame with gaps", start);
    endtask

    task automatic test_after_done();
        int start;
        start = errors;
        load_extra(EXTRA_WORDS);
        run_beats(EXTRA_WORDS * `IB_WORD_BITS, 1'b0, 1'b1);
        assert (busy_faults == 0 && done_faults == 0) else begin
            $display("error at %0d ns: busy or done moved in %0d cycles of the extra input",
                     $time, busy_faults + done_faults);
            errors++;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (done && !busy) else begin
            $display("error at %0d ns: busy %b done %b after extra beats, expected 0 and 1",
                     $time, busy, done);
            errors++;
        end
        readback_frame();
        report_test(5, "input after done", start);
    endtask

    initial begin
        rng_state    = 32'hc40c1b79;
        errors       = 0;
        tests_failed = 0;
        busy_faults  = 0;
        done_faults  = 0;
        rst_n        = 1'b0;
        bit_in       = '0;
        bit_valid    = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;

        apply_reset();
        test_reset_state();
        test_full_frame();
        test_flags();
        test_gaps();
        test_after_done();

        $display("%0d of 5 tests passed, %0d errors in total", 5 - tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/ib_addr_ctrl_top.sv ====
module ib_addr_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ib_frame_pkg::lane_bits_t bit_in,
    input  logic                     bit_valid,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  ib_bus_pkg::bus_addr_t    wb_adr,
    output ib_bus_pkg::bus_data_t    wb_dat_o,
    output logic                     wb_ack,
    output logic                     busy,
    output logic                     done
);

    import ib_frame_pkg::*;

    // Skew line to controller and bank
    lane_bits_t  lane_valid;
    lane_words_t lane_word;

    // Controller to bank
    lane_bits_t  wr_strobe;
    lane_slots_t wr_slot;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    lane_skew_line lane_skew_line_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .bit_in     (bit_in),
        .bit_valid  (bit_valid),
        .lane_valid (lane_valid),
        .lane_word  (lane_word)
    );

    //////////////////////////////////////////////////
    // Slot addressing and flags
    //////////////////////////////////////////////////

    slot_write_ctrl slot_write_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_valid),
        .wr_strobe  (wr_strobe),
        .wr_slot    (wr_slot),
        .busy       (busy),
        .done       (done)
    );

    //////////////////////////////////////////////////
    // Storage and read port
    //////////////////////////////////////////////////

    word_bank word_bank_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_strobe (wr_strobe),
        .wr_slot   (wr_slot),
        .lane_word (lane_word),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack)
    );

endmodule

// ==== hdl/word_bank.sv ====
`include "ib_macros.svh"

module word_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ib_frame_pkg::lane_bits_t  wr_strobe,
    input  ib_frame_pkg::lane_slots_t wr_slot,
    input  ib_frame_pkg::lane_words_t lane_word,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  ib_bus_pkg::bus_addr_t     wb_adr,
    output ib_bus_pkg::bus_data_t     wb_dat_o,
    output logic                      wb_ack
);

    import ib_frame_pkg::*;
    import ib_bus_pkg::*;

    localparam int DEPTH = `IB_LANES * `IB_SLOTS;

    // Flat store, entry lane*IB_SLOTS+slot
    // Each lane owns IB_SLOTS consecutive words
    word_t     mem [DEPTH];

    bus_addr_t wr_adr [`IB_LANES];

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    // Lane and slot fields map onto the flat index
    always_comb begin
        for (int k = 0; k < `IB_LANES; k++) begin
            wr_adr[k].fields.lane = k[`IB_LANE_BITS-1:0];
            wr_adr[k].fields.slot = wr_slot[k];
        end
    end

    // Several lanes may write in the same cycle, always to distinct entries
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int k = 0; k < `IB_LANES; k++) begin
                if (wr_strobe[k]) begin
                    mem[wr_adr[k].raw] <= lane_word[k];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Wishbone classic slave, read only
    //////////////////////////////////////////////////

    // Registered ack, one pulse per request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // Writes are acked but leave the bank alone
    always_ff @(posedge clk) begin
        if (wb_cyc && wb_stb && !wb_ack && !wb_we) begin
            wb_dat_o <= mem[wb_adr.raw];
        end
    end

endmodule

// ==== hdl/slot_write_ctrl.sv ====
`include "ib_macros.svh"

module slot_write_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ib_frame_pkg::lane_bits_t  lane_valid,
    output ib_frame_pkg::lane_bits_t  wr_strobe,
    output ib_frame_pkg::lane_slots_t wr_slot,
    output logic                      busy,
    output logic                      done
);

    import ib_frame_pkg::*;

    logic [`IB_BIT_CNT_BITS-1:0] bit_cnt;
    slot_t                       cur_slot;
    logic                        slots_full;

    logic                        strobe_0;
    slot_t                       slot_0;
    logic [`IB_LANES-1:1]        strobe_chain;
    slot_t [`IB_LANES-1:1]       slot_chain;

    logic                        last_write;

    //////////////////////////////////////////////////
    // Lane 0 bit and slot counting
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= '0;
            cur_slot   <= '0;
            slots_full <= 1'b0;
            strobe_0   <= 1'b0;
        end else begin
            strobe_0 <= 1'b0;
            // Beats after the last slot is counted are dropped
            if (lane_valid[0] && !slots_full) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == `IB_BIT_CNT_BITS'(`IB_WORD_BITS - 1)) begin
                    strobe_0 <= 1'b1;
                    cur_slot <= cur_slot + 1'b1;
                    if (cur_slot == slot_t'(`IB_SLOTS - 1)) begin
                        slots_full <= 1'b1;
                    end
                end
            end
        end
    end

    // Slot travels with the strobe
    always_ff @(posedge clk) begin
        if (lane_valid[0] && !slots_full && bit_cnt == `IB_BIT_CNT_BITS'(`IB_WORD_BITS - 1)) begin
            slot_0 <= cur_slot;
        end
    end

    //////////////////////////////////////////////////
    // Strobe and slot skew down the lanes
    //////////////////////////////////////////////////

    assign wr_strobe = {strobe_chain, strobe_0};
    assign wr_slot   = {slot_chain, slot_0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_chain <= '0;
        end else begin
            strobe_chain <= wr_strobe[`IB_LANES-2:0];
        end
    end

    always_ff @(posedge clk) begin
        slot_chain <= wr_slot[`IB_LANES-2:0];
    end

    //////////////////////////////////////////////////
    // Frame flags
    //////////////////////////////////////////////////

    // Last lane writing its last slot closes the frame
    assign last_write = wr_strobe[`IB_LANES-1] &&
                        (wr_slot[`IB_LANES-1] == slot_t'(`IB_SLOTS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (last_write) begin
            busy <= 1'b0;
            done <= 1'b1;
        end else if (lane_valid[0] && !done) begin
            busy <= 1'b1;
        end
    end

endmodule

// ==== hdl/lane_skew_line.sv ====
`include "ib_macros.svh"

module lane_skew_line (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ib_frame_pkg::lane_bits_t  bit_in,
    input  logic                      bit_valid,
    output ib_frame_pkg::lane_bits_t  lane_valid,
    output ib_frame_pkg::lane_words_t lane_word
);

    //////////////////////////////////////////////////
    // Valid strobe skew
    //////////////////////////////////////////////////

    // Lane k sees bit_valid delayed by k cycles
    logic [`IB_LANES-1:1] valid_dly;

    assign lane_valid = {valid_dly, bit_valid};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_dly <= '0;
        end else begin
            // Each stage takes the strobe of the lane before it
            valid_dly <= lane_valid[`IB_LANES-2:0];
        end
    end

    //////////////////////////////////////////////////
    // Per lane deserialiser
    //////////////////////////////////////////////////

    for (genvar k = 0; k < `IB_LANES; k++) begin : g_lane

        // New bit enters at the LSB, so the first bit ends up as the MSB
        // after IB_WORD_BITS valid beats
        always_ff @(posedge clk) begin
            if (lane_valid[k]) begin
                lane_word[k] <= {lane_word[k][`IB_WORD_BITS-2:0], bit_in[k]};
            end
        end

    end

endmodule

// ==== hdl/ib_bus_pkg.sv ====
`include "ib_macros.svh"

package ib_bus_pkg;

    //////////////////////////////////////////////////
    // Wishbone read port
    //////////////////////////////////////////////////

    // Word address of the bank
    // Raw view indexes the flat memory directly
    // Field view splits it into lane and slot, lane in the upper bits
    typedef union packed {
        logic [`IB_LANE_BITS+`IB_SLOT_BITS-1:0] raw;
        struct packed {
            logic [`IB_LANE_BITS-1:0] lane;
            logic [`IB_SLOT_BITS-1:0] slot;
        } fields;
    } bus_addr_t;

    // Read data, one stored word
    typedef logic [`IB_WORD_BITS-1:0] bus_data_t;

endpackage

// ==== hdl/ib_frame_pkg.sv ====
`include "ib_macros.svh"

package ib_frame_pkg;

    //////////////////////////////////////////////////
    // Single lane view
    //////////////////////////////////////////////////

    // One assembled word, first bit received sits in the MSB
    typedef logic [`IB_WORD_BITS-1:0] word_t;

    // One bit per lane
    // Serial data, skewed valids and write strobes all use this
    typedef logic [`IB_LANES-1:0] lane_bits_t;

    // Slot index inside one lane memory
    typedef logic [`IB_SLOT_BITS-1:0] slot_t;

    //////////////////////////////////////////////////
    // Whole frame view
    //////////////////////////////////////////////////

    // Assembled word of every lane, index is the lane number
    typedef word_t [`IB_LANES-1:0] lane_words_t;

    // Slot to be written, per lane
    typedef slot_t [`IB_LANES-1:0] lane_slots_t;

endpackage

// ==== include/ib_macros.svh ====
`ifndef IB_MACROS_SVH
`define IB_MACROS_SVH

//////////////////////////////////////////////////
// Frame geometry
//////////////////////////////////////////////////

// Serial lanes, one bit per lane per valid beat
`define IB_LANES 32

// Bits assembled into one word
`define IB_WORD_BITS 32

// Words kept per lane
`define IB_SLOTS 4

//////////////////////////////////////////////////
// Derived index widths
//////////////////////////////////////////////////

`define IB_LANE_BITS 5
`define IB_SLOT_BITS 2

// Counts 0 to IB_WORD_BITS-1 bits of lane 0
`define IB_BIT_CNT_BITS 5

`endif
